//--- compile.f
design/aluPkg.sv
design/aluLane.sv
design/opDispatch.sv
design/resultCollect.sv
design/aluArray.sv
testbench/aluArray_props.sv
testbench/aluArrayTb.sv

//--- design/aluArray.sv
/* Top of the ALU cluster, an APB3 slave with numLanes ALU lanes (1 to 8).
   Only wiring lives here. */
`timescale 1ns/100ps
`default_nettype none

module aluArray import aluPkg::*; #(
  parameter int numLanes        = 4,
  parameter bit twoStageShifter = 1'b0
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [dataW-1:0] pwdata,
  output logic [dataW-1:0] prdata,
  output logic             pready,
  output logic             pslverr
);

  logic [numLanes-1:0]            start;
  logic [numLanes-1:0]            busy;
  logic [numLanes-1:0]            laneDone;
  logic [numLanes-1:0][dataW-1:0] laneResult;
  logic [numLanes-1:0][dataW-1:0] result;
  logic [numLanes-1:0]            done;
  logic [numLanes-1:0]            resRead;
  logic [dataW-1:0]               opA;       // Broadcast to every lane
  logic [dataW-1:0]               opB;
  funcT                           func;
  logic                           qual;

  opDispatch #(
    .numLanes (numLanes)
  ) u_opDispatch (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy),
    .result  (result),
    .done    (done),
    .start   (start),
    .opA     (opA),
    .opB     (opB),
    .func    (func),
    .qual    (qual),
    .resRead (resRead)
  );

  for (genvar i = 0; i < numLanes; i++) begin : gLane
    aluLane #(
      .twoStageShifter (twoStageShifter)
    ) u_lane (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start[i]),
      .opA        (opA),
      .opB        (opB),
      .func       (func),
      .qual       (qual),
      .busy       (busy[i]),
      .laneDone   (laneDone[i]),
      .laneResult (laneResult[i])
    );
  end

  resultCollect #(
    .numLanes (numLanes)
  ) u_resultCollect (
    .clk        (clk),
    .rstN       (rstN),
    .laneDone   (laneDone),
    .laneResult (laneResult),
    .resRead    (resRead),
    .result     (result),
    .done       (done)
  );

endmodule

`default_nettype wire

//--- design/aluLane.sv
/* One RV32I ALU lane. Non-shift results appear one cycle after start; shifts are serial
   and hold busy until done. A start while busy is not expected from the dispatcher. */
`timescale 1ns/100ps
`default_nettype none

module aluLane import aluPkg::*; #(
  parameter bit twoStageShifter = 1'b0  // Take 4-bit steps while more than 4 remain
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             start,       // One-cycle launch pulse
  input  logic [dataW-1:0] opA,
  input  logic [dataW-1:0] opB,
  input  funcT             func,
  input  logic             qual,        // SUB / SRA qualifier
  output logic             busy,        // Serial shift in progress
  output logic             laneDone,    // One-cycle completion pulse
  output logic [dataW-1:0] laneResult   // Also the shift register
);

  logic [4:0]       shamt;      // Remaining shift amount
  funcT             funcR;      // Latched at start
  logic             qualR;      // Latched at start
  logic             isShift;
  logic [dataW:0]   minus;      // opA - opB with borrow in the top bit
  logic [dataW-1:0] sum;
  logic             lt;         // Signed less-than
  logic             ltu;        // Unsigned less-than
  logic [dataW-1:0] aluOut;     // Single-cycle result
  logic             fill;       // Bit shifted in from the left
  logic [dataW-1:0] step1;      // Next value for a 1-bit step
  logic [dataW-1:0] step4;      // Next value for a 4-bit step
  logic             bigStep;

  assign isShift = (func == fnSll) || (func == fnSr);

  // One subtractor serves SUB, SLT and SLTU
  assign minus = {1'b0, opA} + {1'b1, ~opB} + {{dataW{1'b0}}, 1'b1};
  assign sum   = opA + opB;
  assign ltu   = minus[dataW];
  // Differing signs decide by opA alone
  assign lt    = (opA[dataW-1] ^ opB[dataW-1]) ? opA[dataW-1] : minus[dataW];

  always_comb begin
    case (func)
      fnAdd:   aluOut = qual ? minus[dataW-1:0] : sum;
      fnSlt:   aluOut = {{(dataW-1){1'b0}}, lt};
      fnSltu:  aluOut = {{(dataW-1){1'b0}}, ltu};
      fnXor:   aluOut = opA ^ opB;
      fnOr:    aluOut = opA | opB;
      fnAnd:   aluOut = opA & opB;
      default: aluOut = opA;  // Shifts load opA instead
    endcase
  end

  // Shift steps use the latched function since the broadcast inputs may have moved on
  assign fill = qualR & laneResult[dataW-1];  // Sign fill for SRA only

  always_comb begin
    if (funcR == fnSll) begin
      step1 = {laneResult[dataW-2:0], 1'b0};
      step4 = {laneResult[dataW-5:0], 4'b0000};
    end else begin
      step1 = {fill, laneResult[dataW-1:1]};
      step4 = {{4{fill}}, laneResult[dataW-1:4]};
    end
  end

  assign bigStep = twoStageShifter && (shamt > 5'd4);
  assign busy    = (shamt != 5'd0);

  // Sequencing of the shifter and the done pulse
  always_ff @(posedge clk) begin
    if (!rstN) begin
      shamt    <= 5'd0;
      laneDone <= 1'b0;
    end else if (start) begin
      shamt    <= isShift ? opB[4:0] : 5'd0;
      laneDone <= !isShift || (opB[4:0] == 5'd0);  // Zero shift finishes at once
    end else if (bigStep) begin
      shamt    <= shamt - 5'd4;  // Never reaches zero here
      laneDone <= 1'b0;
    end else if (shamt != 5'd0) begin
      shamt    <= shamt - 5'd1;
      laneDone <= (shamt == 5'd1);  // Last step
    end else begin
      laneDone <= 1'b0;
    end
  end

  // Result and shift register
  always_ff @(posedge clk) begin
    if (start) begin
      funcR      <= func;
      qualR      <= qual;
      laneResult <= aluOut;
    end else if (bigStep) begin
      laneResult <= step4;
    end else if (shamt != 5'd0) begin
      laneResult <= step1;
    end
  end

endmodule

`default_nettype wire

//--- design/aluPkg.sv
/* Shared constants of the ALU cluster. Register offsets assume an 8-bit APB address
   and word-aligned accesses; the lane field of a command word is 3 bits wide. */
`default_nettype none

package aluPkg;

  localparam int dataW = 32;  // Operand and result width

  // RV32I funct3 encodings
  typedef enum logic [2:0] {
    fnAdd  = 3'b000,  // ADD, SUB when qualified
    fnSll  = 3'b001,  // Shift left logical
    fnSlt  = 3'b010,  // Signed compare
    fnSltu = 3'b011,  // Unsigned compare
    fnXor  = 3'b100,
    fnSr   = 3'b101,  // SRL, SRA when qualified
    fnOr   = 3'b110,
    fnAnd  = 3'b111
  } funcT;

  // APB register map, byte offsets
  localparam logic [7:0] addrOpA     = 8'h00;  // Operand A, read/write
  localparam logic [7:0] addrOpB     = 8'h04;  // Operand B, read/write
  localparam logic [7:0] addrCmd     = 8'h08;  // Command, write starts a lane
  localparam logic [7:0] addrStatus  = 8'h0C;  // Busy [7:0], done [15:8]
  localparam logic [7:0] addrResBase = 8'h10;  // Lane i result at base + 4*i

  // Command word fields, funct3 sits in [2:0]
  localparam int cmdQualBit = 3;  // SUB / SRA select
  localparam int cmdLaneLsb = 8;  // Lowest bit of the lane index

endpackage

`default_nettype wire

//--- design/opDispatch.sv
/* APB3 front end of the cluster. Start and resRead are combinational from the access
   cycle; a CMD write to a busy lane waits, a bad lane or offset gets pslverr. */
`timescale 1ns/100ps
`default_nettype none

module opDispatch import aluPkg::*; #(
  parameter int numLanes = 4  // 1 to 8
) (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [7:0]                         paddr,
  input  logic [dataW-1:0]                   pwdata,
  output logic [dataW-1:0]                   prdata,
  output logic                               pready,
  output logic                               pslverr,
  input  logic [numLanes-1:0]                busy,
  input  logic [numLanes-1:0][dataW-1:0]     result,
  input  logic [numLanes-1:0]                done,
  output logic [numLanes-1:0]                start,
  output logic [dataW-1:0]                   opA,
  output logic [dataW-1:0]                   opB,
  output funcT                               func,
  output logic                               qual,
  output logic [numLanes-1:0]                resRead   // Clears done of the read lane
);

  localparam int         laneFieldW = 3;  // Up to 8 lanes
  localparam logic [7:0] resEnd     = addrResBase + 8'(4 * numLanes);

  logic                  access;     // Access phase of a transfer
  logic                  hitOpA;
  logic                  hitOpB;
  logic                  hitCmd;
  logic                  hitStatus;
  logic                  hitRes;
  logic                  mapped;
  logic [7:0]            resOff;
  logic [laneFieldW-1:0] resIdx;
  logic [laneFieldW-1:0] cmdLane;
  logic [numLanes-1:0]   laneSel;    // One-hot target of a command
  logic [numLanes-1:0]   resSel;     // One-hot result being addressed
  logic                  cmdWrite;
  logic                  laneBad;    // Lane index not implemented
  logic                  laneWait;   // Target still shifting
  logic [dataW-1:0]      cmdReg;     // Last accepted command
  logic [dataW-1:0]      statusWord;
  logic [dataW-1:0]      resWord;

  assign access    = psel & penable;
  assign hitOpA    = (paddr == addrOpA);
  assign hitOpB    = (paddr == addrOpB);
  assign hitCmd    = (paddr == addrCmd);
  assign hitStatus = (paddr == addrStatus);
  assign hitRes    = (paddr >= addrResBase) && (paddr < resEnd) && (paddr[1:0] == 2'b00);
  assign mapped    = hitOpA | hitOpB | hitCmd | hitStatus | hitRes;

  assign resOff  = paddr - addrResBase;
  assign resIdx  = resOff[2 +: laneFieldW];
  assign cmdLane = pwdata[cmdLaneLsb +: laneFieldW];

  // Lane decoders; an index past numLanes selects nothing
  always_comb begin
    for (int i = 0; i < numLanes; i++) begin
      laneSel[i] = (cmdLane == laneFieldW'(i));
      resSel[i]  = hitRes && (resIdx == laneFieldW'(i));
    end
  end

  assign laneBad  = ~|laneSel;
  assign cmdWrite = access & pwrite & hitCmd;
  assign laneWait = cmdWrite & ~laneBad & (|(busy & laneSel));  // Back-pressure

  assign pready  = ~laneWait;
  assign pslverr = access & (~mapped | (cmdWrite & laneBad));

  // Launch on the completing cycle, command fields straight from the bus
  assign start   = {numLanes{cmdWrite & ~laneWait}} & laneSel;
  assign func    = funcT'(pwdata[2:0]);
  assign qual    = pwdata[cmdQualBit];
  assign resRead = {numLanes{access & ~pwrite}} & resSel;

  always_comb begin
    statusWord                  = '0;
    statusWord[numLanes-1:0]    = busy;
    statusWord[8 +: numLanes]   = done;
  end

  always_comb begin
    resWord = '0;
    for (int i = 0; i < numLanes; i++) begin
      resWord = resWord | (result[i] & {dataW{resSel[i]}});
    end
  end

  // Read data, zero outside a read
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hitOpA) begin
        prdata = opA;
      end else if (hitOpB) begin
        prdata = opB;
      end else if (hitCmd) begin
        prdata = cmdReg;
      end else if (hitStatus) begin
        prdata = statusWord;
      end else if (hitRes) begin
        prdata = resWord;
      end
    end
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (access && pwrite && hitOpA) opA <= pwdata;
    if (access && pwrite && hitOpB) opB <= pwdata;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cmdReg <= '0;
    end else if (|start) begin
      cmdReg <= pwdata;  // Only accepted commands are kept
    end
  end

endmodule

`default_nettype wire

//--- design/resultCollect.sv
/* Per-lane result registers with sticky done flags. A completion in the same cycle
   as the result read keeps the flag set. */
`timescale 1ns/100ps
`default_nettype none

module resultCollect import aluPkg::*; #(
  parameter int numLanes = 4
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic [numLanes-1:0]            laneDone,    // Completion pulses
  input  logic [numLanes-1:0][dataW-1:0] laneResult,
  input  logic [numLanes-1:0]            resRead,     // Result read this cycle
  output logic [numLanes-1:0][dataW-1:0] result,
  output logic [numLanes-1:0]            done
);

  // Capture each lane on its own pulse
  always_ff @(posedge clk) begin
    for (int i = 0; i < numLanes; i++) begin
      if (laneDone[i]) begin
        result[i] <= laneResult[i];
      end
    end
  end

  // Sticky flags; set has priority over clear
  always_ff @(posedge clk) begin
    if (!rstN) begin
      done <= '0;
    end else begin
      done <= laneDone | (done & ~resRead);
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds and runs the ALU cluster testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
  --top-module aluArrayTb -f compile.f --Mdir "$buildDir" -o aluArraySim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/aluArraySim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Result: FAILED" "$logFile"; then
  exit 1
fi
exit 0

//--- testbench/aluArrayTb.sv
/* Testbench for aluArray with 4 lanes and the 1-bit shifter. All DUT access goes
   through APB; expected values come from an RV32I model. */
`timescale 1ns/100ps
`default_nettype none

module aluArrayTb import aluPkg::*; ();

  localparam int numLanes   = 4;
  localparam int cycleLimit = 20000;  // Tests take about 6000 cycles

  logic             clk;
  logic             rstN;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [dataW-1:0] pwdata;
  logic [dataW-1:0] prdata;
  logic             pready;
  logic             pslverr;
  logic [31:0]      seed = 32'h64d2_5973;  // LCG state
  logic [31:0]      rdVal;                 // Read data of the last transfer
  int               waitCnt;               // Wait states of the last transfer
  int               errors = 0;
  int               cycles = 0;
  funcT             logicOps [6] = '{fnAdd, fnSlt, fnSltu, fnXor, fnOr, fnAnd};
  int               shiftAmts [5] = '{0, 1, 4, 5, 31};

  aluArray #(.numLanes(numLanes), .twoStageShifter(1'b0)) u_aluArray (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: tests still running after %0d cycles", cycleLimit);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] lcgNext();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // RV32I reference with the shift amount from the low 5 bits of b
  function automatic logic [31:0] refAlu(funcT f, logic q, logic [31:0] a, logic [31:0] b);
    case (f)
      fnAdd:   return q ? a - b : a + b;
      fnSll:   return a << b[4:0];
      fnSlt:   return {31'd0, $signed(a) < $signed(b)};
      fnSltu:  return {31'd0, a < b};
      fnXor:   return a ^ b;
      fnSr:    return q ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];  // SRA or SRL
      fnOr:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] cmdWord(int lane, funcT f, logic q);
    return (32'(lane) << cmdLaneLsb) | (32'(q) << cmdQualBit) | 32'(f);
  endfunction

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // Inputs change on the falling edge and outputs are sampled 1 ns later
  task automatic busXfer(logic wr, logic [7:0] addr, logic [31:0] wdata, logic expErr = 1'b0);
    @(negedge clk);
    psel    = 1'b1;  // Setup cycle
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;  // Access cycle
    waitCnt = 0;
    #1;
    while (!pready) begin
      waitCnt++;
      @(negedge clk);
      #1;
    end
    rdVal = prdata;
    checkEq($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(expErr));
    @(negedge clk);  // Completed on the rising edge before
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic launch(int lane, funcT f, logic q, logic [31:0] a, logic [31:0] b);
    busXfer(1'b1, addrOpA, a);
    busXfer(1'b1, addrOpB, b);
    busXfer(1'b1, addrCmd, cmdWord(lane, f, q));
  endtask

  task automatic waitDone(int lane);  // Polls STATUS until the done bit is set
    busXfer(1'b0, addrStatus, 32'd0);
    while (!rdVal[8 + lane]) begin
      busXfer(1'b0, addrStatus, 32'd0);
    end
  endtask

  // Result read followed by a check that the done flag is clear
  task automatic checkResult(int lane, logic [31:0] want);
    busXfer(1'b0, 8'(addrResBase + 4 * lane), 32'd0);
    checkEq($sformatf("result[%0d]", lane), rdVal, want);
    busXfer(1'b0, addrStatus, 32'd0);
    checkEq($sformatf("done[%0d]", lane), 32'(rdVal[8 + lane]), 32'd0);
  endtask

  task automatic runOp(int lane, funcT f, logic q, logic [31:0] a, logic [31:0] b);
    launch(lane, f, q, a, b);
    waitDone(lane);
    checkResult(lane, refAlu(f, q, a, b));
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] doneBefore;
    funcT        f;
    int          assertFails;
    logic [31:0] pa [numLanes];
    logic [31:0] pb [numLanes];
    rstN    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h00;
    pwdata  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Single-cycle ops spread over all lanes
    for (int i = 0; i < 200; i++) begin
      r = lcgNext();
      a = lcgNext();
      b = lcgNext();
      if (i % 8 == 0) begin
        b = a;  // Equal operands
      end else if (i % 8 == 1) begin
        b[31] = ~a[31];  // Sign bits differ
      end
      f = logicOps[int'(r % 6)];
      runOp(i % numLanes, f, (f == fnAdd) && r[16], a, b);
    end

    // Shifts with fixed amounts then random ones
    for (int i = 0; i < 24; i++) begin
      a = lcgNext();
      b = lcgNext();
      if (i < 15) begin
        b[4:0] = 5'(shiftAmts[i / 3]);
      end
      f = (i % 3 == 0) ? fnSll : fnSr;
      runOp(i % numLanes, f, i % 3 == 2, a, b);
    end

    // Second command to lane 2 while it shifts 31 places
    a = lcgNext();
    b = 32'd31;
    launch(2, fnSll, 1'b0, a, b);
    busXfer(1'b0, addrStatus, 32'd0);
    checkEq("busy[2]", 32'(rdVal[2]), 32'd1);
    busXfer(1'b1, addrCmd, cmdWord(2, fnSr, 1'b1));  // SRA on the same operands
    assert (waitCnt > 0) else begin
      errors++;
      $display("CMD write to busy lane 2 completed without wait states");
    end
    waitDone(2);
    checkResult(2, refAlu(fnSll, 1'b0, a, b));
    waitDone(2);
    checkResult(2, refAlu(fnSr, 1'b1, a, b));

    // Shifts of 24 to 31 on all lanes back to back
    for (int l = 0; l < numLanes; l++) begin
      pa[l] = lcgNext();
      pb[l] = lcgNext() | 32'h18;
      launch(l, (l == 0) ? fnSll : fnSr, l > 1, pa[l], pb[l]);
    end
    busXfer(1'b0, addrStatus, 32'd0);
    assert ($countones(rdVal[numLanes-1:0]) > 1) else begin
      errors++;
      $display("Fewer than two lanes busy after back-to-back shift commands");
    end
    for (int l = 0; l < numLanes; l++) begin
      waitDone(l);
      checkResult(l, refAlu((l == 0) ? fnSll : fnSr, l > 1, pa[l], pb[l]));
    end

    // Decode errors while done[1] is pending
    a = lcgNext();
    b = lcgNext();
    launch(1, fnXor, 1'b0, a, b);
    waitDone(1);
    doneBefore = rdVal;
    busXfer(1'b0, 8'h40, 32'd0, 1'b1);                      // Unmapped offset
    busXfer(1'b1, addrCmd, cmdWord(5, fnAdd, 1'b0), 1'b1);  // No lane 5
    busXfer(1'b0, addrStatus, 32'd0);
    checkEq("done bits", 32'(rdVal[15:8]), 32'(doneBefore[15:8]));
    busXfer(1'b0, addrOpA, 32'd0);
    checkEq("opA", rdVal, a);
    busXfer(1'b0, addrOpB, 32'd0);
    checkEq("opB", rdVal, b);
    checkResult(1, refAlu(fnXor, 1'b0, a, b));

    assertFails = u_aluArray.u_opDispatch.u_props.failCount;
    $display("Summary: %0d check errors, %0d assertion failures", errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/aluArray_props.sv
/* Concurrent APB and lane checks, bound into every opDispatch. Assumes one APB
   master and that no lane is started while it is busy. */
`timescale 1ns/100ps
`default_nettype none

module aluArrayProps #(
  parameter int numLanes = 4
) (
  input logic                clk,
  input logic                rstN,
  input logic                psel,
  input logic                penable,
  input logic                pready,
  input logic                pslverr,
  input logic [numLanes-1:0] start,
  input logic [numLanes-1:0] busy,
  input logic [numLanes-1:0] done
);

  int         failCount = 0;       // Read by the testbench summary
  logic [5:0] busyRun [numLanes];  // Consecutive busy cycles per lane

  always_ff @(posedge clk) begin
    for (int i = 0; i < numLanes; i++) begin
      if (!rstN || !busy[i]) begin
        busyRun[i] <= 6'd0;
      end else if (busyRun[i] != 6'd63) begin
        busyRun[i] <= busyRun[i] + 6'd1;  // Saturates
      end
    end
  end

  errAtCompletion: assert property (@(posedge clk) disable iff (!rstN)
    pslverr |-> psel && penable && pready)
    else begin
      failCount++;
      $error("pslverr high outside a completing access cycle");
    end

  startOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(start))
    else begin
      failCount++;
      $error("More than one lane start pulse at once");
    end

  for (genvar i = 0; i < numLanes; i++) begin : gBusy
    busyBound: assert property (@(posedge clk) disable iff (!rstN) busyRun[i] < 6'd32)
      else begin
        failCount++;
        $error("Lane %0d busy for more than 32 cycles", i);
      end
  end

  resetState: assert property (@(posedge clk)
    $rose(rstN) |-> pready && !pslverr && start == '0 && busy == '0 && done == '0)
    else begin
      failCount++;
      $error("Bus or lane state not idle after reset");
    end

endmodule

bind opDispatch aluArrayProps #(
  .numLanes (numLanes)
) u_props (
  .clk     (clk),
  .rstN    (rstN),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .start   (start),
  .busy    (busy),
  .done    (done)
);

`default_nettype wire
